/* hdl/mipsPkg.sv */
package mipsPkg;

    typedef logic [31:0] word_t;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        RType = 6'h00,
        J     = 6'h02,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        ADDI  = 6'h08,
        LW    = 6'h23,
        SW    = 6'h2b
    } opcode_t;

    // funct field of R-type, bits 5:0
    typedef enum logic [5:0] {
        JR  = 6'h08,
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } funct_t;

    // operation class from the main decoder
    typedef enum logic [1:0] {
        AluAdd   = 2'b00,
        AluSub   = 2'b01,
        AluFunct = 2'b10
    } aluOp_t;

    typedef enum logic [2:0] {
        Fetch     = 3'd0,
        Decode    = 3'd1,
        Execute   = 3'd2,
        Memory    = 3'd3,
        Writeback = 3'd4
    } phase_t;

endpackage

/* hdl/opcodeControl.sv */
`timescale 1ns/1ps

module opcodeControl (
    input  mipsPkg::opcode_t opcode,
    input  mipsPkg::funct_t  funct,
    output logic             regDst,
    output logic             jump,
    output logic             jumpRegister,
    output logic             branch,
    output logic             branchNe,
    output logic             memRead,
    output logic             memtoReg,
    output logic             memWrite,
    output logic             aluSrc,
    output logic             regWrite,
    output mipsPkg::aluOp_t  aluOp
);
    import mipsPkg::*;

    logic isR;
    logic isRAlu;
    logic isJ;
    logic isJr;
    logic isBeq;
    logic isBne;
    logic isAddi;
    logic isLw;
    logic isSw;

    // one-hot instruction classes
    always_comb begin
        isR = (opcode == RType);
        isJ = (opcode == J);
        isBeq = (opcode == BEQ);
        isBne = (opcode == BNE);
        isAddi = (opcode == ADDI);
        isLw = (opcode == LW);
        isSw = (opcode == SW);
        // funct only matters for R-type
        isJr = isR && (funct == JR);
        isRAlu = isR && (funct inside {ADD, SUB, AND, OR, SLT});
    end

    assign regDst = isR;
    assign jump = isJ;
    assign jumpRegister = isJr;
    assign branch = isBeq;
    assign branchNe = isBne;
    assign memRead = isLw;
    assign memtoReg = isLw;
    assign memWrite = isSw;
    assign aluSrc = isAddi || isLw || isSw;
    // unknown opcodes and functs leave this low
    assign regWrite = isRAlu || isAddi || isLw;

    always_comb begin
        if (isR) begin
            aluOp = AluFunct;
        end else if (isBeq || isBne) begin
            aluOp = AluSub;
        end else begin
            aluOp = AluAdd;
        end
    end

endmodule

/* hdl/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  mipsPkg::aluOp_t aluOp,
    input  mipsPkg::funct_t funct,
    input  mipsPkg::word_t  a,
    input  mipsPkg::word_t  b,
    output mipsPkg::word_t  result,
    output logic            zero
);
    import mipsPkg::*;

    funct_t operation;

    // fixed classes map onto the matching funct code
    always_comb begin
        case (aluOp)
            AluSub:   operation = SUB;
            AluFunct: operation = funct;
            default:  operation = ADD;
        endcase
    end

    always_comb begin
        case (operation)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            // signed compare
            SLT:     result = {31'd0, $signed(a) < $signed(b)};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* hdl/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic           clk,
    input  logic           reset,
    input  logic           writeEnable,
    input  logic [4:0]     readAddrA,
    input  logic [4:0]     readAddrB,
    input  logic [4:0]     writeAddr,
    input  mipsPkg::word_t writeData,
    output mipsPkg::word_t readDataA,
    output mipsPkg::word_t readDataB
);
    import mipsPkg::*;

    word_t registers [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != 5'd0)) begin
            registers[writeAddr] <= writeData;
        end
    end

    // register zero always reads as zero
    assign readDataA = (readAddrA == 5'd0) ? '0 : registers[readAddrA];
    assign readDataB = (readAddrB == 5'd0) ? '0 : registers[readAddrB];

endmodule

/* hdl/programCounter.sv */
`timescale 1ns/1ps

module programCounter (
    input  logic           clk,
    input  logic           reset,
    input  logic           advance,
    input  logic           branchTaken,
    input  logic           jump,
    input  logic           jumpRegister,
    input  mipsPkg::word_t immediate,
    input  mipsPkg::word_t jumpTarget,
    input  mipsPkg::word_t registerTarget,
    output mipsPkg::word_t pc
);
    import mipsPkg::*;

    word_t pcPlus4;
    word_t nextPc;

    always_comb begin
        pcPlus4 = pc + 32'd4;
        if (jumpRegister) begin
            nextPc = registerTarget;
        end else if (jump) begin
            // jumpTarget arrives as target times 4
            nextPc = {pcPlus4[31:28], jumpTarget[27:0]};
        end else if (branchTaken) begin
            nextPc = pcPlus4 + {immediate[29:0], 2'b00};
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (advance) begin
            pc <= nextPc;
        end
    end

endmodule

/* hdl/cycleSequencer.sv */
`timescale 1ns/1ps

module cycleSequencer (
    input  logic            clk,
    input  logic            reset,
    input  logic            run,
    input  logic            needsMemory,
    output mipsPkg::phase_t phase,
    output logic            loadInstruction,
    output logic            loadExecute,
    output logic            memoryAccess,
    output logic            writeback
);
    import mipsPkg::*;

    phase_t nextPhase;

    always_comb begin
        case (phase)
            // hold in fetch while the core is idle
            Fetch:     nextPhase = run ? Decode : Fetch;
            Decode:    nextPhase = Execute;
            Execute:   nextPhase = needsMemory ? Memory : Writeback;
            Memory:    nextPhase = Writeback;
            default:   nextPhase = Fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= Fetch;
        end else begin
            phase <= nextPhase;
        end
    end

    // one-cycle phase enables
    assign loadInstruction = (phase == Decode);
    assign loadExecute = (phase == Execute);
    assign memoryAccess = (phase == Memory);
    // also serves as the retire strobe
    assign writeback = (phase == Writeback);

endmodule

/* hdl/wordMemory.sv */
`timescale 1ns/1ps

module wordMemory #(
    parameter int depthLog2 = 8
) (
    input  logic                 clk,
    input  logic                 writeEnable,
    input  logic [depthLog2-1:0] address,
    input  mipsPkg::word_t       writeData,
    output mipsPkg::word_t       readData
);
    import mipsPkg::*;

    word_t storage [2**depthLog2];

    // read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            storage[address] <= writeData;
        end
        readData <= storage[address];
    end

endmodule

/* hdl/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore #(
    parameter int imemDepthLog2 = 8,
    parameter int dmemDepthLog2 = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     run,
    input  logic                     progWrite,
    input  logic [imemDepthLog2-1:0] progAddr,
    input  mipsPkg::word_t           progData,
    output logic                     retire,
    output mipsPkg::word_t           retirePc,
    output logic                     retireRegWrite,
    output logic [4:0]               retireReg,
    output mipsPkg::word_t           retireData
);
    import mipsPkg::*;

    word_t instruction;
    word_t fetchData;
    word_t aluResult;
    word_t rtValue;
    word_t loadData;
    logic  zeroFlag;

    word_t pc;
    word_t readDataA;
    word_t readDataB;
    word_t signImm;
    word_t aluB;
    word_t aluOut;
    word_t writeData;
    logic  aluZero;
    logic  [4:0] writeReg;
    logic  regWriteEnable;
    logic  [imemDepthLog2-1:0] imemAddress;

    logic   regDst;
    logic   jump;
    logic   jumpRegister;
    logic   branch;
    logic   branchNe;
    logic   memRead;
    logic   memtoReg;
    logic   memWrite;
    logic   aluSrc;
    logic   regWrite;
    aluOp_t aluOp;

    phase_t phase;
    logic   loadInstruction;
    logic   loadExecute;
    logic   memoryAccess;
    logic   writeback;

    // program port only while idle
    assign imemAddress = run ? pc[imemDepthLog2+1:2] : progAddr;

    wordMemory #(
        .depthLog2(imemDepthLog2)
    ) instructionMemory (
        .clk(clk),
        .writeEnable(progWrite && !run),
        .address(imemAddress),
        .writeData(progData),
        .readData(fetchData)
    );

    // instruction register feeding the decoder
    always_ff @(posedge clk) begin
        if (reset) begin
            instruction <= '0;
        end else if (loadInstruction) begin
            instruction <= fetchData;
        end
    end

    opcodeControl u_opcodeControl (
        .opcode(opcode_t'(instruction[31:26])),
        .funct(funct_t'(instruction[5:0])),
        .regDst(regDst),
        .jump(jump),
        .jumpRegister(jumpRegister),
        .branch(branch),
        .branchNe(branchNe),
        .memRead(memRead),
        .memtoReg(memtoReg),
        .memWrite(memWrite),
        .aluSrc(aluSrc),
        .regWrite(regWrite),
        .aluOp(aluOp)
    );

    cycleSequencer u_cycleSequencer (
        .clk(clk),
        .reset(reset),
        .run(run),
        .needsMemory(memRead || memWrite),
        .phase(phase),
        .loadInstruction(loadInstruction),
        .loadExecute(loadExecute),
        .memoryAccess(memoryAccess),
        .writeback(writeback)
    );

    assign signImm = {{16{instruction[15]}}, instruction[15:0]};
    assign writeReg = regDst ? instruction[15:11] : instruction[20:16];
    assign writeData = memtoReg ? loadData : aluResult;
    assign regWriteEnable = writeback && regWrite && (writeReg != 5'd0);

    registerFile u_registerFile (
        .clk(clk),
        .reset(reset),
        .writeEnable(regWriteEnable),
        .readAddrA(instruction[25:21]),
        .readAddrB(instruction[20:16]),
        .writeAddr(writeReg),
        .writeData(writeData),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    assign aluB = aluSrc ? signImm : readDataB;

    aluUnit u_aluUnit (
        .aluOp(aluOp),
        .funct(funct_t'(instruction[5:0])),
        .a(readDataA),
        .b(aluB),
        .result(aluOut),
        .zero(aluZero)
    );

    // execute results
    always_ff @(posedge clk) begin
        if (loadExecute) begin
            aluResult <= aluOut;
            zeroFlag <= aluZero;
            rtValue <= readDataB;
        end
    end

    // registered read data lands in writeback
    wordMemory #(
        .depthLog2(dmemDepthLog2)
    ) dataMemory (
        .clk(clk),
        .writeEnable(memoryAccess && memWrite),
        .address(aluResult[dmemDepthLog2+1:2]),
        .writeData(rtValue),
        .readData(loadData)
    );

    programCounter u_programCounter (
        .clk(clk),
        .reset(reset),
        .advance(writeback),
        .branchTaken((branch && zeroFlag) || (branchNe && !zeroFlag)),
        .jump(jump),
        .jumpRegister(jumpRegister),
        .immediate(signImm),
        .jumpTarget({4'd0, instruction[25:0], 2'b00}),
        .registerTarget(readDataA),
        .pc(pc)
    );

    // pc still holds the retiring address during writeback
    assign retire = writeback;
    assign retirePc = pc;
    assign retireRegWrite = writeback && regWrite && (writeReg != 5'd0);
    assign retireReg = retireRegWrite ? writeReg : 5'd0;
    assign retireData = retireRegWrite ? writeData : '0;

endmodule

/* verif/tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
    parameter int halfPeriod = 5,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        // release on a falling edge like the other stimulus
        @(negedge clk);
        reset = 1'b0;
    end

    always #halfPeriod clk = ~clk;

endmodule

/* verif/mipsCore_properties.sv */
`timescale 1ns/1ps

module mipsCore_properties (
    input logic            clk,
    input logic            reset,
    input mipsPkg::phase_t phase,
    input logic            retire,
    input logic            memRead,
    input logic            memWrite,
    input mipsPkg::word_t  zeroRegister
);
    import mipsPkg::*;

    // sequencer comes out of reset in fetch
    resetToFetch: assert property (@(posedge clk) reset |=> phase == Fetch)
        else $error("phase is not Fetch after reset");

    retireOneCycle: assert property (@(posedge clk) disable iff (reset)
        retire |=> !retire)
        else $error("retire held for more than one cycle");

    // memory phase only for lw and sw
    memoryNeedsAccess: assert property (@(posedge clk) disable iff (reset)
        phase == Memory |-> (memRead || memWrite))
        else $error("Memory phase entered without a memory instruction");

    // storage of register 0 never leaves its reset value
    noZeroWrite: assert property (@(posedge clk) disable iff (reset)
        zeroRegister == '0)
        else $error("register 0 was written");

endmodule

/* verif/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb;

    localparam int imemLog2 = 8;
    localparam int dmemLog2 = 8;
    // retires per test 19 + 13 + 14 + 5 + 7
    localparam int totalRetires = 58;
    // up to 5 cycles per retire plus margin for reset and loading
    localparam int watchdogCycles = totalRetires * 5 + 400;

    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ = 6'h02;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;
    localparam logic [5:0] fnJr = 6'h08;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    logic clk;
    logic reset;
    logic run;
    logic progWrite;
    logic [imemLog2-1:0] progAddr;
    logic [31:0] progData;
    logic retire;
    logic [31:0] retirePc;
    logic retireRegWrite;
    logic [4:0] retireReg;
    logic [31:0] retireData;

    // model state
    logic [31:0] imemImage [2**imemLog2] = '{default: '0};
    logic [31:0] dataMem [2**dmemLog2] = '{default: '0};
    logic [31:0] regs [32] = '{default: '0};
    logic [31:0] modelPc = '0;
    logic [31:0] lfsrState = 32'hbf1b_1474;

    logic [31:0] code [$];
    logic [31:0] endPc;
    logic loading;
    logic [31:0] expPc;
    logic expWrite;
    logic [4:0] expReg;
    logic [31:0] expData;
    int errorCount = 0;
    int checkCount = 0;
    int retireCount = 0;
    int doneCount = 0;
    int idleRetires = 0;

    tbClock clockGen (
        .clk(clk),
        .reset(reset)
    );

    mipsCore #(
        .imemDepthLog2(imemLog2),
        .dmemDepthLog2(dmemLog2)
    ) u_mipsCore (
        .clk(clk),
        .reset(reset),
        .run(run),
        .progWrite(progWrite),
        .progAddr(progAddr),
        .progData(progData),
        .retire(retire),
        .retirePc(retirePc),
        .retireRegWrite(retireRegWrite),
        .retireReg(retireReg),
        .retireData(retireData)
    );

    bind mipsCore mipsCore_properties u_properties (
        .clk(clk),
        .reset(reset),
        .phase(phase),
        .retire(retire),
        .memRead(memRead),
        .memWrite(memWrite),
        .zeroRegister(u_registerFile.registers[0])
    );

    // right-shifting Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        int n;
        value = '0;
        for (n = 0; n < count; n++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
        return value;
    endfunction

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
            input logic [4:0] rd, input logic [5:0] fn);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input logic [25:0] target);
        return {opJ, target};
    endfunction

    function automatic logic [5:0] arithmeticFunct(input int sel);
        case (sel)
            0: return fnAdd;
            1: return fnSub;
            2: return fnAnd;
            3: return fnOr;
            default: return fnSlt;
        endcase
    endfunction

    // ISA model stepping one instruction per call
    function automatic void executeInstruction(output logic [31:0] pcOut,
            output logic writeOut, output logic [4:0] regOut, output logic [31:0] dataOut);
        logic [31:0] instr;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] imm;
        logic [31:0] address;
        logic [31:0] pcPlus4;
        logic [31:0] nextPc;
        logic [31:0] result;
        logic [4:0] dest;
        logic writes;
        instr = imemImage[modelPc[imemLog2+1:2]];
        rsVal = regs[instr[25:21]];
        rtVal = regs[instr[20:16]];
        imm = {{16{instr[15]}}, instr[15:0]};
        address = rsVal + imm;
        pcPlus4 = modelPc + 32'd4;
        nextPc = pcPlus4;
        result = '0;
        dest = instr[20:16];
        writes = 1'b0;
        case (instr[31:26])
            opRType: begin
                dest = instr[15:11];
                writes = 1'b1;
                case (instr[5:0])
                    fnAdd: result = rsVal + rtVal;
                    fnSub: result = rsVal - rtVal;
                    fnAnd: result = rsVal & rtVal;
                    fnOr: result = rsVal | rtVal;
                    fnSlt: result = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
                    fnJr: begin
                        nextPc = rsVal;
                        writes = 1'b0;
                    end
                    default: writes = 1'b0;
                endcase
            end
            opAddi: begin
                result = rsVal + imm;
                writes = 1'b1;
            end
            opLw: begin
                result = dataMem[address[dmemLog2+1:2]];
                writes = 1'b1;
            end
            opSw: dataMem[address[dmemLog2+1:2]] = rtVal;
            opBeq: begin
                if (rsVal == rtVal) begin
                    nextPc = pcPlus4 + (imm << 2);
                end
            end
            opBne: begin
                if (rsVal != rtVal) begin
                    nextPc = pcPlus4 + (imm << 2);
                end
            end
            opJ: nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
            default: writes = 1'b0;
        endcase
        // register zero stays zero
        writes = writes && (dest != 5'd0);
        if (writes) begin
            regs[dest] = result;
        end
        pcOut = modelPc;
        writeOut = writes;
        regOut = writes ? dest : 5'd0;
        dataOut = writes ? result : '0;
        modelPc = nextPc;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
            errorCount++;
        end
    endtask

    // compare on the falling edge where the retire trace is stable
    always @(negedge clk) begin
        if (!reset && retire) begin
            if (loading) begin
                $display("retire at pc %h while run was low for program loading", retirePc);
                idleRetires++;
                errorCount++;
            end
            executeInstruction(expPc, expWrite, expReg, expData);
            checkValue("retirePc", retirePc, expPc);
            checkValue("retireRegWrite", {31'd0, retireRegWrite}, {31'd0, expWrite});
            checkValue("retireReg", {27'd0, retireReg}, {27'd0, expReg});
            checkValue("retireData", retireData, expData);
            retireCount++;
            if (retirePc == endPc) begin
                doneCount++;
            end
        end
    end

    task automatic emit(input logic [31:0] word);
        code.push_back(word);
    endtask

    // load the queued program with run low and run it up to the closing j 0
    task automatic runProgram(input string name);
        int startErrors;
        int startRetires;
        int target;
        int idx;
        startErrors = errorCount;
        startRetires = retireCount;
        code.push_back(jType(26'd0));
        endPc = 32'(4 * (code.size() - 1));
        loading = 1'b1;
        for (idx = 0; idx < code.size(); idx++) begin
            @(negedge clk);
            progWrite = 1'b1;
            progAddr = idx[imemLog2-1:0];
            progData = code[idx];
            imemImage[idx] = code[idx];
        end
        @(negedge clk);
        progWrite = 1'b0;
        // idle gap where the core must stay quiet
        repeat (4) @(negedge clk);
        loading = 1'b0;
        target = doneCount + 1;
        run = 1'b1;
        wait (doneCount == target);
        run = 1'b0;
        code.delete();
        $display("test %s: %0d retires, %0d errors", name, retireCount - startRetires,
            errorCount - startErrors);
    endtask

    initial begin : mainSequence
        logic [15:0] slots [6];
        int k;
        run = 1'b0;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        loading = 1'b0;
        endPc = '1;
        wait (!reset);
        @(negedge clk);

        // random signed operands and then each R-type ALU op twice
        for (k = 1; k <= 8; k++) begin
            emit(iType(opAddi, 5'd0, 5'(k), 16'(takeBits(16))));
        end
        for (k = 0; k < 10; k++) begin
            emit(rType(5'(1 + takeBits(3)), 5'(1 + takeBits(3)), 5'(9 + takeBits(3)),
                arithmeticFunct(k % 5)));
        end
        runProgram("arithmetic");

        for (k = 0; k < 6; k++) begin
            slots[k] = 16'(takeBits(dmemLog2) << 2);
            emit(iType(opSw, 5'd0, 5'(1 + k), slots[k]));
        end
        for (k = 0; k < 6; k++) begin
            emit(iType(opLw, 5'd0, 5'(21 + k), slots[k]));
        end
        runProgram("loadStore");

        emit(iType(opAddi, 5'd0, 5'd1, 16'd5));
        emit(iType(opAddi, 5'd0, 5'd2, 16'd5));
        // forward taken branch skips one word
        emit(iType(opBeq, 5'd1, 5'd2, 16'd1));
        emit(iType(opAddi, 5'd0, 5'd3, 16'd111));
        emit(iType(opBne, 5'd1, 5'd2, 16'd1));
        emit(iType(opAddi, 5'd0, 5'd4, 16'd3));
        // loop body at 24 counts down by one
        emit(iType(opAddi, 5'd4, 5'd4, 16'hffff));
        emit(iType(opBne, 5'd4, 5'd0, 16'hfffe));
        emit(iType(opBeq, 5'd4, 5'd1, 16'd1));
        emit(iType(opAddi, 5'd0, 5'd5, 16'd7));
        runProgram("branches");

        emit(jType(26'd3));
        emit(iType(opAddi, 5'd0, 5'd6, 16'd1));
        emit(iType(opAddi, 5'd0, 5'd6, 16'd2));
        emit(iType(opAddi, 5'd0, 5'd7, 16'd24));
        emit(rType(5'd7, 5'd0, 5'd0, fnJr));
        emit(iType(opAddi, 5'd0, 5'd6, 16'd3));
        emit(iType(opAddi, 5'd0, 5'd8, 16'd77));
        runProgram("jumps");

        emit(iType(opAddi, 5'd0, 5'd0, 16'd1234));
        emit(rType(5'd1, 5'd2, 5'd0, fnAdd));
        emit(iType(opSw, 5'd0, 5'd1, 16'd0));
        emit(iType(opLw, 5'd0, 5'd0, 16'd0));
        // reads of register 0 after the dropped writes
        emit(rType(5'd0, 5'd0, 5'd9, fnOr));
        emit(rType(5'd0, 5'd1, 5'd10, fnSub));
        runProgram("registerZero");

        $display("test runGating: %0d retires while run was low", idleRetires);
        $display("summary: %0d retires, %0d checks, %0d errors", retireCount, checkCount,
            errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired, retire stopped after %0d retires", retireCount);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* list.f */
hdl/mipsPkg.sv
hdl/opcodeControl.sv
hdl/aluUnit.sv
hdl/registerFile.sv
hdl/programCounter.sv
hdl/cycleSequencer.sv
hdl/wordMemory.sv
hdl/mipsCore.sv
verif/tbClock.sv
verif/mipsCore_properties.sv
verif/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module mipsCoreTb \
    -f list.f -o mipsCoreSim || exit 1
./obj_dir/mipsCoreSim | tee /dev/stderr | grep -qx "Testbench passed" && exit 0 || exit 1
